// File: files.f
+incdir+bench
common/booth_pkg.sv
booth/booth_operand_prep.sv
booth/booth_row_encoder.sv
verilog/cla_adder.sv
booth/pp_reduce_tree.sv
verilog/booth_mul_top.sv
bench/booth_mul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Booth multiplier testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f files.f \
	--top-module booth_mul_tb \
	-Mdir obj_dir \
	-o booth_mul_sim

status=0
./obj_dir/booth_mul_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -F -q "** FAIL **" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit "$status"
fi
exit 0

// File: bench/booth_mul_tests.svh
`ifndef BOOTH_MUL_TESTS_SVH
`define BOOTH_MUL_TESTS_SVH

task automatic issue_op(input operand_t x, input operand_t y, input logic sgn);
	@(posedge clk);
	in_valid <= 1'b1;
	a        <= x;
	b        <= y;
	sign     <= sgn;
endtask

task automatic idle_cycles(input int n);
	repeat (n) begin
		@(posedge clk);
		in_valid <= 1'b0;
	end
endtask

// stop issuing, let the pipe empty, then compare the result count
task automatic drain_and_count(input int base, input int n, input string name);
	int waited;
	waited = 0;
	@(posedge clk);
	in_valid <= 1'b0;
	while (exp_q.size() != 0 && waited < PIPE_LAT + 2) begin
		@(posedge clk);
		waited++;
	end
	@(posedge clk);
	if (done_cnt - base != n) begin
		$display("%s: only %0d of %0d results came back", name, done_cnt - base, n);
		miss_cnt++;
		exp_q.delete();
	end
endtask

task automatic test_reset();
	repeat (IDLE_CYC) begin
		@(negedge clk);
		check_valid(out_valid, 1'b0, "out_valid while idle");
	end
endtask

task automatic test_unsigned_corners();
	operand_t vals [7];
	int base;
	// 0x6666 gives the +2 digit, 0x8000 a top row of +1
	vals = '{16'h0000, 16'h0001, 16'hFFFF, 16'h8000, 16'hAAAA, 16'h5555, 16'h6666};
	base = done_cnt;
	for (int i = 0; i < 7; i++) begin
		for (int j = 0; j < 7; j++) begin
			issue_op(vals[i], vals[j], 1'b0);
		end
	end
	drain_and_count(base, UNS_OPS, "unsigned corners");
endtask

task automatic test_signed_corners();
	int xs [SGN_OPS];
	int ys [SGN_OPS];
	int base;
	xs = '{-32768, -1, -32768, 32767, -1, 1, 32767, -12345, 1234, 0};
	ys = '{-32768, -1, 32767, -32768, 1, -1, 32767, 321, -5678, -32768};
	base = done_cnt;
	for (int i = 0; i < SGN_OPS; i++) begin
		issue_op(operand_t'(xs[i]), operand_t'(ys[i]), 1'b1);
	end
	drain_and_count(base, SGN_OPS, "signed corners");
endtask

// back to back, so PIPE_LAT operations are in flight
task automatic test_random_mix();
	logic [31:0] ra;
	logic [31:0] rb;
	logic [31:0] rs;
	int base;
	base = done_cnt;
	for (int i = 0; i < RND_OPS; i++) begin
		ra = $random(seed);
		rb = $random(seed);
		rs = $random(seed);
		issue_op(ra[15:0], rb[15:0], rs[0]);
	end
	drain_and_count(base, RND_OPS, "random mix");
endtask

task automatic test_gapped_stream();
	logic [31:0] ra;
	logic [31:0] rb;
	logic [31:0] rs;
	logic [31:0] rg;
	int gap;
	int base;
	base = done_cnt;
	for (int i = 0; i < GAP_OPS; i++) begin
		ra = $random(seed);
		rb = $random(seed);
		rs = $random(seed);
		rg = $random(seed);
		issue_op(ra[15:0], rb[15:0], rs[0]);
		gap = int'(rg[7:0]) % (GAP_MAX + 1);
		if (gap > 0) begin
			idle_cycles(gap);	// latency and stray pulses caught by the monitor
		end
	end
	drain_and_count(base, GAP_OPS, "gapped stream");
endtask

`endif

// File: bench/booth_mul_tb.sv
`timescale 1ns/100ps
`default_nettype none

module booth_mul_tb import booth_pkg::*; ();

	localparam int RST_CYC   = 5;
	localparam int IDLE_CYC  = 10;
	localparam int UNS_OPS   = 49;	// 7 corner values, all pairs
	localparam int SGN_OPS   = 10;
	localparam int RND_OPS   = 200;
	localparam int GAP_OPS   = 50;
	localparam int GAP_MAX   = 4;
	localparam int TEST_CNT  = 5;
	localparam int MARGIN    = 40;
	localparam int TOTAL_OPS = UNS_OPS + SGN_OPS + RND_OPS + GAP_OPS;
	// every op, worst case idle gaps, drain per test
	localparam int TIMEOUT_CYC = RST_CYC + IDLE_CYC + TOTAL_OPS + GAP_OPS * GAP_MAX +
		TEST_CNT * (PIPE_LAT + 4) + MARGIN;

	logic     clk;
	logic     rst;
	logic     in_valid;
	operand_t a;
	operand_t b;
	logic     sign;
	logic     out_valid;
	product_t product;

	product_t            exp_q [$];
	product_t            exp_v;
	logic [PIPE_LAT-1:0] vhist;	// in_valid of the last cycles, bit 0 newest
	int                  cycle;
	int                  done_cnt;
	int                  prod_errs;
	int                  valid_errs;
	int                  miss_cnt;
	integer              seed;

	booth_mul_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.sign      (sign),
		.out_valid (out_valid),
		.product   (product)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// product of the operands as 16-bit signed or unsigned numbers, kept to 32 bits
	function automatic product_t expected_product(operand_t x, operand_t y, logic sgn);
		longint xl;
		longint yl;
		if (sgn) begin
			xl = longint'($signed(x));
			yl = longint'($signed(y));
		end else begin
			xl = longint'(x);
			yl = longint'(y);
		end
		return product_t'(xl * yl);
	endfunction

	task automatic check_product(input product_t got, input product_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			prod_errs++;
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
			valid_errs++;
		end
	endtask

	// outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (!rst) begin
			check_valid(out_valid, vhist[PIPE_LAT-1], "out_valid");
			if (out_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("result %h at %0t arrived with no operation pending",
						product, $time);
					miss_cnt++;
				end else begin
					exp_v = exp_q.pop_front();
					check_product(product, exp_v, "product");
					done_cnt++;
				end
			end
			if (in_valid) begin
				exp_q.push_back(expected_product(a, b, sign));
			end
			vhist = {vhist[PIPE_LAT-2:0], in_valid};
		end
	end

	`include "booth_mul_tests.svh"

	initial begin : watchdog
		@(posedge clk);
		while (cycle < TIMEOUT_CYC) begin
			@(posedge clk);
		end
		$display("timeout after %0d cycles, the tests did not finish", cycle);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		seed       = 60;
		cycle      = 0;
		done_cnt   = 0;
		prod_errs  = 0;
		valid_errs = 0;
		miss_cnt   = 0;
		vhist      = '0;
		rst      <= 1'b1;
		in_valid <= 1'b0;
		a        <= '0;
		b        <= '0;
		sign     <= 1'b0;
		repeat (RST_CYC) @(posedge clk);
		rst <= 1'b0;

		test_reset();
		test_unsigned_corners();
		test_signed_corners();
		test_random_mix();
		test_gapped_stream();

		if (exp_q.size() != 0) begin
			$display("%0d results never came out of the multiplier", exp_q.size());
			miss_cnt += exp_q.size();
		end
		$display("errors: product %0d, valid %0d, missing or unexpected %0d",
			prod_errs, valid_errs, miss_cnt);
		if (prod_errs + valid_errs + miss_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/booth_mul_top.sv
`timescale 1ns/100ps
`default_nettype none

module booth_mul_top import booth_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  operand_t a,
	input  operand_t b,
	input  logic     sign,
	output logic     out_valid,
	output product_t product
);

	logic               prep_valid;
	mcand_t             mcand;
	logic [MPLR_W-1:0]  mplr;
	logic [MPLR_W:0]    mplr_ext;	// top window reaches one bit past mplr
	product_t           pp_rows [ROW_CNT];
	logic [ROW_CNT-1:0] negs;

	booth_operand_prep prep_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.a          (a),
		.b          (b),
		.sign       (sign),
		.prep_valid (prep_valid),
		.mcand      (mcand),
		.mplr       (mplr)
	);

	assign mplr_ext = {mplr[MPLR_W-1], mplr};

	for (genvar i = 0; i < ROW_CNT; i++) begin : row
		booth_row_encoder #(
			.ROW_IDX (i)
		) enc_i (
			.window (mplr_ext[2*i +: 3]),	// bits 2i+2 .. 2i
			.mcand  (mcand),
			.pp_row (pp_rows[i]),
			.neg    (negs[i])
		);
	end

	pp_reduce_tree tree_i (
		.clk       (clk),
		.rst       (rst),
		.row_valid (prep_valid),
		.pp_rows   (pp_rows),
		.negs      (negs),
		.out_valid (out_valid),
		.product   (product)
	);

endmodule

`default_nettype wire

// File: booth/pp_reduce_tree.sv
`timescale 1ns/100ps
`default_nettype none

module pp_reduce_tree import booth_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               row_valid,
	input  product_t           pp_rows [ROW_CNT],
	input  logic [ROW_CNT-1:0] negs,
	output logic               out_valid,
	output product_t           product
);

	product_t           rows_q [ROW_CNT];
	logic [ROW_CNT-1:0] negs_q;
	logic               valid_q;
	product_t           neg_row;
	product_t           lvl [RED_LAYERS+1][RED_ROWS];
	product_t           sum_row;
	product_t           carry_row;
	product_t           sum_c;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= row_valid;
		end
	end

	always_ff @(posedge clk) begin
		rows_q <= pp_rows;
		negs_q <= negs;
	end

	// each negate bit lands at the lsb of its own row
	always_comb begin
		neg_row = '0;
		for (int i = 0; i < ROW_CNT; i++) begin
			neg_row[2*i] = negs_q[i];
		end
	end

	// layered 3:2 compression, leftover rows pass straight to the next layer
	always_comb begin
		int n;
		int grp;
		lvl = '{default: '0};
		for (int r = 0; r < ROW_CNT; r++) begin
			lvl[0][r] = rows_q[r];
		end
		lvl[0][ROW_CNT] = neg_row;
		n = RED_ROWS;
		for (int l = 0; l < RED_LAYERS; l++) begin
			grp = n / 3;
			for (int j = 0; j < grp; j++) begin
				lvl[l+1][2*j] = lvl[l][3*j] ^ lvl[l][3*j+1] ^ lvl[l][3*j+2];
				lvl[l+1][2*j+1] = ((lvl[l][3*j] & lvl[l][3*j+1]) |
					(lvl[l][3*j] & lvl[l][3*j+2]) |
					(lvl[l][3*j+1] & lvl[l][3*j+2])) << 1;	// top carry drops, mod 2^32
			end
			for (int r = 0; r < n % 3; r++) begin
				lvl[l+1][2*grp+r] = lvl[l][3*grp+r];
			end
			n = 2 * grp + n % 3;
		end
	end

	assign sum_row   = lvl[RED_LAYERS][0];
	assign carry_row = lvl[RED_LAYERS][1];

	cla_adder final_add_i (
		.x   (sum_row),
		.y   (carry_row),
		.sum (sum_c)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		product <= sum_c;
	end

	a_product_known: assert property (
		@(posedge clk) disable iff (rst) out_valid |-> !$isunknown(product)
	) else $error("product unknown while out_valid is high");

endmodule

`default_nettype wire

// File: verilog/cla_adder.sv
`timescale 1ns/100ps
`default_nettype none

module cla_adder import booth_pkg::*; (
	input  product_t x,
	input  product_t y,
	output product_t sum
);

	localparam int GRP_CNT = PROD_W / 4;

	product_t           g;
	product_t           p;
	product_t           c;
	logic [GRP_CNT-1:0] gc;	// carry into each 4-bit group

	assign g = x & y;
	assign p = x ^ y;
	assign gc[0] = 1'b0;

	for (genvar k = 0; k < GRP_CNT; k++) begin : grp
		localparam int B = 4 * k;

		assign c[B]   = gc[k];
		assign c[B+1] = g[B] | (p[B] & gc[k]);
		assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & gc[k]);
		assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B]) |
			(p[B+2] & p[B+1] & p[B] & gc[k]);

		// last group carry out is the dropped bit 32
		if (k < GRP_CNT - 1) begin : carry_out
			logic grp_g;
			logic grp_p;

			assign grp_g = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1]) |
				(p[B+3] & p[B+2] & p[B+1] & g[B]);
			assign grp_p = p[B+3] & p[B+2] & p[B+1] & p[B];
			assign gc[k+1] = grp_g | (grp_p & gc[k]);	// ripple between groups
		end
	end

	assign sum = p ^ c;

	always_comb begin
		if (!$isunknown({x, y})) begin
			assert (sum == product_t'(x + y))
				else $error("cla sum mismatch %h + %h -> %h", x, y, sum);
		end
	end

endmodule

`default_nettype wire

// File: booth/booth_row_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module booth_row_encoder import booth_pkg::*; #(
	parameter int ROW_IDX = 0
) (
	input  booth_window_t window,
	input  mcand_t        mcand,
	output product_t      pp_row,
	output logic          neg
);

	booth_op_t          op;
	logic [MCAND_W:0]   mag;	// one bit wider to hold 2x
	logic [MCAND_W:0]   sel;

	always_comb begin
		case (window)
			3'b000, 3'b111: op = BOOTH_ZERO;
			3'b001, 3'b010: op = BOOTH_POS1;
			3'b011:         op = BOOTH_POS2;
			3'b100:         op = BOOTH_NEG2;
			3'b101, 3'b110: op = BOOTH_NEG1;
			default:        op = BOOTH_ZERO;
		endcase
	end

	always_comb begin
		case (op)
			BOOTH_POS1, BOOTH_NEG1: mag = {mcand[MCAND_W-1], mcand};
			BOOTH_POS2, BOOTH_NEG2: mag = {mcand, 1'b0};
			default:                mag = '0;
		endcase
	end

	assign neg = (op == BOOTH_NEG1) || (op == BOOTH_NEG2);
	assign sel = neg ? ~mag : mag;	// one's complement, +1 comes from the negate row

	// sign-extend to product width, then move to this row's weight
	assign pp_row = {{(PROD_W - MCAND_W - 1){sel[MCAND_W]}}, sel} << (2 * ROW_IDX);

	always_comb begin
		int digit;
		digit = int'(window[1]) + int'(window[0]) - 2 * int'(window[2]);	// radix-4 value
		if (!$isunknown({window, mcand})) begin
			assert (op inside {BOOTH_ZERO, BOOTH_POS1, BOOTH_POS2, BOOTH_NEG1, BOOTH_NEG2} &&
				(pp_row + (product_t'(neg) << (2 * ROW_IDX))) ==
				product_t'((digit * int'($signed(mcand))) << (2 * ROW_IDX)))
				else $error("row %0d bad booth decode, window %b opcode %0d",
					ROW_IDX, window, op);
		end
	end

endmodule

`default_nettype wire

// File: booth/booth_operand_prep.sv
`timescale 1ns/100ps
`default_nettype none

module booth_operand_prep import booth_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  operand_t         a,
	input  operand_t         b,
	input  logic             sign,
	output logic             prep_valid,
	output mcand_t           mcand,
	output logic [MPLR_W-1:0] mplr
);

	logic a_ext;
	logic b_ext;

	assign a_ext = sign & a[OPND_W-1];	// zero in unsigned mode
	assign b_ext = sign & b[OPND_W-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			prep_valid <= 1'b0;
		end else begin
			prep_valid <= in_valid;
		end
	end

	// operands only move when a new pair is accepted
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mcand <= {a_ext, a};
			mplr  <= {b_ext, b, 1'b0};	// implicit zero below bit 0
		end
	end

	a_prep_valid_known: assert property (
		@(posedge clk) disable iff (rst) !$isunknown(prep_valid)
	) else $error("prep_valid unknown after reset");

endmodule

`default_nettype wire

// File: common/booth_pkg.sv
`default_nettype none

package booth_pkg;

	localparam int OPND_W   = 16;
	localparam int PROD_W   = 2 * OPND_W;
	localparam int ROW_CNT  = OPND_W / 2 + 1;	// one extra row for the unsigned top digit
	localparam int MCAND_W  = OPND_W + 1;
	localparam int MPLR_W   = 2 * ROW_CNT;
	localparam int PIPE_LAT = 3;

	// partial product rows plus the row of negate bits
	localparam int RED_ROWS   = ROW_CNT + 1;
	localparam int RED_LAYERS = 5;	// 10 -> 7 -> 5 -> 4 -> 3 -> 2

	typedef logic [OPND_W-1:0]  operand_t;
	typedef logic [PROD_W-1:0]  product_t;
	typedef logic [MCAND_W-1:0] mcand_t;
	typedef logic [2:0]         booth_window_t;

	typedef enum logic [2:0] {
		BOOTH_ZERO = 3'd0,
		BOOTH_POS1 = 3'd1,
		BOOTH_POS2 = 3'd2,
		BOOTH_NEG1 = 3'd3,
		BOOTH_NEG2 = 3'd4
	} booth_op_t;

endpackage

`default_nettype wire
